// File: core_pkg.sv
package core_pkg;

	// widths with a meaning
	typedef logic [31:0] word_t;
	typedef logic [11:0] pc_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [3:0]  alu_op_t;
	typedef logic [1:0]  div_op_t;
	typedef logic [2:0]  dm_sel_t;
	typedef logic [2:0]  sel_data_t;
	typedef logic [1:0]  store_sel_t;
	typedef logic [3:0]  byte_en_t;

	// alu operations
	localparam alu_op_t ALU_ADD    = 4'd0;
	localparam alu_op_t ALU_SUB    = 4'd1;
	localparam alu_op_t ALU_SLL    = 4'd2;
	localparam alu_op_t ALU_SLT    = 4'd3;
	localparam alu_op_t ALU_SLTU   = 4'd4;
	localparam alu_op_t ALU_XOR    = 4'd5;
	localparam alu_op_t ALU_SRL    = 4'd6;
	localparam alu_op_t ALU_SRA    = 4'd7;
	localparam alu_op_t ALU_OR     = 4'd8;
	localparam alu_op_t ALU_AND    = 4'd9;
	localparam alu_op_t ALU_PASS_B = 4'd10;

	// divide operations
	localparam div_op_t DIV_DIV  = 2'd0;
	localparam div_op_t DIV_DIVU = 2'd1;
	localparam div_op_t DIV_REM  = 2'd2;
	localparam div_op_t DIV_REMU = 2'd3;

	// result source, load passes the address on to memory
	localparam sel_data_t SEL_ALU  = 3'd0;
	localparam sel_data_t SEL_DIV  = 3'd1;
	localparam sel_data_t SEL_PC4  = 3'd2;
	localparam sel_data_t SEL_LOAD = 3'd3;

	localparam store_sel_t ST_BYTE = 2'd0;
	localparam store_sel_t ST_HALF = 2'd1;
	localparam store_sel_t ST_WORD = 2'd2;

	localparam int DIV_STEPS = 32;

	typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} div_state_e;

	typedef struct packed {
		logic       valid;
		pc_t        pc4;
		pc_t        pc;
		word_t      fwd_opa;
		word_t      fwd_opb;
		word_t      fwd_store;
		word_t      imm;
		reg_idx_t   rd;
		alu_op_t    alu_op;
		logic       alu_src_imm;
		logic       div_valid;
		div_op_t    div_op;
		logic       is_stype;
		logic       wr_en;
		dm_sel_t    dm_select;
		sel_data_t  sel_data;
		store_sel_t store_select;
	} id_exe_t;

	typedef struct packed {
		logic      valid;
		pc_t       pc;
		word_t     result;
		word_t     store_data;
		byte_en_t  byte_en;
		logic      mem_write;
		dm_sel_t   dm_select;
		sel_data_t sel_data;
		reg_idx_t  rd;
		logic      wr_en;
	} exe_mem_t;

endpackage

// File: id_exe_reg.sv
`timescale 1ns/100ps

module id_exe_reg (
	input  logic              clk,
	input  logic              arst_n,

	// pipeline control levels
	input  logic              en,
	input  logic              stall,
	input  logic              div_busy,
	input  logic              flush,

	// decode bundle in, execute bundle out
	input  core_pkg::id_exe_t id_in,
	output core_pkg::id_exe_t exe_q
);

	logic hold;

	// a divide in progress holds the stage like a hazard stall
	assign hold = !en || stall || div_busy;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			exe_q <= '0;
		end else if (flush) begin
			// bubble, valid, wr_en and div_valid all drop to zero
			exe_q <= '0;
		end else if (!hold) begin
			exe_q <= id_in;
		end
	end

endmodule

// File: alu.sv
`timescale 1ns/100ps

module alu (
	input  core_pkg::id_exe_t exe_q,
	output core_pkg::word_t   alu_result
);

	core_pkg::word_t opa;
	core_pkg::word_t opb;
	logic [4:0]      shamt;

	assign opa = exe_q.fwd_opa;

	// immediate replaces rs2 for I-type, loads, stores and lui
	assign opb = exe_q.alu_src_imm ? exe_q.imm : exe_q.fwd_opb;

	assign shamt = opb[4:0];

	always_comb begin
		case (exe_q.alu_op)
			core_pkg::ALU_ADD:
				alu_result = opa + opb;
			core_pkg::ALU_SUB:
				alu_result = opa - opb;
			core_pkg::ALU_SLL:
				alu_result = opa << shamt;
			core_pkg::ALU_SLT:
				alu_result = {31'd0, $signed(opa) < $signed(opb)};
			core_pkg::ALU_SLTU:
				alu_result = {31'd0, opa < opb};
			core_pkg::ALU_XOR:
				alu_result = opa ^ opb;
			core_pkg::ALU_SRL:
				alu_result = opa >> shamt;
			core_pkg::ALU_SRA:
				alu_result = $unsigned($signed(opa) >>> shamt);
			core_pkg::ALU_OR:
				alu_result = opa | opb;
			core_pkg::ALU_AND:
				alu_result = opa & opb;
			// lui, the immediate comes through untouched
			core_pkg::ALU_PASS_B:
				alu_result = opb;
			default:
				alu_result = opa + opb;
		endcase
	end

endmodule

// File: divider.sv
`timescale 1ns/100ps

module divider (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              en,
	input  logic              stall,
	input  logic              flush,
	input  core_pkg::id_exe_t exe_q,
	output core_pkg::word_t   div_result,
	output logic              div_busy,
	output logic              div_done
);

	core_pkg::div_state_e state;
	logic [5:0]           step_cnt;
	core_pkg::word_t      quo;
	core_pkg::word_t      rem;
	core_pkg::word_t      dvsr;
	core_pkg::word_t      mag_a;
	core_pkg::word_t      mag_b;
	core_pkg::word_t      quo_fix;
	core_pkg::word_t      rem_fix;
	logic [32:0]          rem_shift;
	logic [32:0]          diff;
	logic                 start;
	logic                 is_signed;
	logic                 is_rem;
	logic                 neg_a;
	logic                 neg_b;

	assign start     = exe_q.valid && exe_q.div_valid;
	assign is_signed = (exe_q.div_op == core_pkg::DIV_DIV) || (exe_q.div_op == core_pkg::DIV_REM);
	assign is_rem    = (exe_q.div_op == core_pkg::DIV_REM) || (exe_q.div_op == core_pkg::DIV_REMU);

	// operands stay in exe_q for the whole divide
	assign neg_a = is_signed && exe_q.fwd_opa[31];
	assign neg_b = is_signed && exe_q.fwd_opb[31];
	assign mag_a = neg_a ? -exe_q.fwd_opa : exe_q.fwd_opa;
	assign mag_b = neg_b ? -exe_q.fwd_opb : exe_q.fwd_opb;

	// one restoring step, bit 32 set means the trial went negative
	assign rem_shift = {rem, quo[31]};
	assign diff      = rem_shift - {1'b0, dvsr};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= core_pkg::DIV_IDLE;
			step_cnt <= '0;
		end else if (flush) begin
			state    <= core_pkg::DIV_IDLE;
			step_cnt <= '0;
		end else begin
			case (state)
				core_pkg::DIV_IDLE: begin
					step_cnt <= '0;
					if (start)
						state <= core_pkg::DIV_RUN;
				end
				core_pkg::DIV_RUN: begin
					step_cnt <= step_cnt + 6'd1;
					if (step_cnt == 6'(core_pkg::DIV_STEPS - 1))
						state <= core_pkg::DIV_DONE;
				end
				// wait here until the pipeline takes the result
				core_pkg::DIV_DONE: begin
					if (en && !stall)
						state <= core_pkg::DIV_IDLE;
				end
				default: state <= core_pkg::DIV_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == core_pkg::DIV_IDLE) begin
			quo  <= mag_a;
			rem  <= '0;
			dvsr <= mag_b;
		end else if (state == core_pkg::DIV_RUN) begin
			rem <= diff[32] ? rem_shift[31:0] : diff[31:0];
			quo <= {quo[30:0], !diff[32]};
		end
	end

	// sign fix and the RISC-V corner cases
	always_comb begin
		quo_fix = (neg_a ^ neg_b) ? -quo : quo;
		rem_fix = neg_a ? -rem : rem;
		if (exe_q.fwd_opb == '0) begin
			quo_fix = '1;
			rem_fix = exe_q.fwd_opa;
		end else if (is_signed && exe_q.fwd_opa == 32'h8000_0000 && exe_q.fwd_opb == '1) begin
			quo_fix = exe_q.fwd_opa;
			rem_fix = '0;
		end
		div_result = is_rem ? rem_fix : quo_fix;
	end

	assign div_busy = (state == core_pkg::DIV_RUN) || (state == core_pkg::DIV_IDLE && start);
	assign div_done = (state == core_pkg::DIV_DONE);

endmodule

// File: store_align.sv
`timescale 1ns/100ps

module store_align (
	input  core_pkg::id_exe_t  exe_q,
	input  core_pkg::word_t    alu_result,
	output core_pkg::word_t    st_data,
	output core_pkg::byte_en_t st_byte_en
);

	logic [1:0] offset;

	// low address bits pick the lane
	assign offset = alu_result[1:0];

	always_comb begin
		st_data    = exe_q.fwd_store;
		st_byte_en = '0;
		case (exe_q.store_select)
			core_pkg::ST_BYTE: begin
				st_data    = {4{exe_q.fwd_store[7:0]}};
				st_byte_en = 4'b0001 << offset;
			end
			core_pkg::ST_HALF: begin
				st_data    = {2{exe_q.fwd_store[15:0]}};
				st_byte_en = offset[1] ? 4'b1100 : 4'b0011;
			end
			core_pkg::ST_WORD: st_byte_en = 4'b1111;
			default: st_byte_en = '0;
		endcase
		// enables only for real stores
		if (!exe_q.is_stype)
			st_byte_en = '0;
	end

endmodule

// File: exe_mem_reg.sv
`timescale 1ns/100ps

module exe_mem_reg (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               en,
	input  logic               stall,
	input  logic               flush,
	input  logic               div_busy,
	input  core_pkg::id_exe_t  exe_q,
	input  core_pkg::word_t    alu_result,
	input  core_pkg::word_t    div_result,
	input  core_pkg::word_t    st_data,
	input  core_pkg::byte_en_t st_byte_en,
	output core_pkg::exe_mem_t mem_out
);

	core_pkg::exe_mem_t mem_d;

	always_comb begin
		mem_d.valid      = exe_q.valid;
		mem_d.pc         = exe_q.pc;
		mem_d.store_data = st_data;
		mem_d.byte_en    = st_byte_en;
		mem_d.mem_write  = exe_q.is_stype;
		mem_d.dm_select  = exe_q.dm_select;
		mem_d.sel_data   = exe_q.sel_data;
		mem_d.rd         = exe_q.rd;
		mem_d.wr_en      = exe_q.wr_en;
		// loads also take the alu output, it is the address
		case (exe_q.sel_data)
			core_pkg::SEL_DIV: mem_d.result = div_result;
			core_pkg::SEL_PC4: mem_d.result = {20'd0, exe_q.pc4};
			default:           mem_d.result = alu_result;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_out <= '0;
		end else if (en && !stall) begin
			// bubble while a divide is still running or the stage is flushed
			if (div_busy || flush)
				mem_out <= '0;
			else
				mem_out <= mem_d;
		end
	end

endmodule

// File: exe_stage.sv
`timescale 1ns/100ps

module exe_stage (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               en,
	input  logic               stall,
	input  logic               flush,
	input  core_pkg::id_exe_t  id_in,
	output core_pkg::exe_mem_t mem_out,
	output logic               div_busy
);

	core_pkg::id_exe_t  exe_q;
	core_pkg::word_t    alu_result;
	core_pkg::word_t    div_result;
	core_pkg::word_t    st_data;
	core_pkg::byte_en_t st_byte_en;

	id_exe_reg u_id_exe_reg (
		.clk(clk), .arst_n(arst_n), .en(en), .stall(stall),
		.div_busy(div_busy), .flush(flush), .id_in(id_in), .exe_q(exe_q)
	);

	alu u_alu (.exe_q(exe_q), .alu_result(alu_result));

	// busy alone releases both registers, done is not needed here
	divider u_divider (
		.clk(clk), .arst_n(arst_n), .en(en), .stall(stall), .flush(flush),
		.exe_q(exe_q), .div_result(div_result), .div_busy(div_busy), .div_done()
	);

	store_align u_store_align (
		.exe_q(exe_q), .alu_result(alu_result), .st_data(st_data), .st_byte_en(st_byte_en)
	);

	exe_mem_reg u_exe_mem_reg (
		.clk(clk), .arst_n(arst_n), .en(en), .stall(stall), .flush(flush),
		.div_busy(div_busy), .exe_q(exe_q), .alu_result(alu_result),
		.div_result(div_result), .st_data(st_data), .st_byte_en(st_byte_en),
		.mem_out(mem_out)
	);

endmodule

// File: exe_checker.sv
`timescale 1ns/100ps

module exe_checker (
	input logic               clk,
	input logic               arst_n,
	input logic               en,
	input logic               stall,
	input logic               div_busy,
	input core_pkg::exe_mem_t mem_out
);

	core_pkg::exe_mem_t expect_q[$];
	int                 due_q[$];
	core_pkg::exe_mem_t want;
	int                 due;
	core_pkg::exe_mem_t last_out = '0;
	logic               loaded = 1'b0;
	int                 moved_edges = 0;
	int                 mismatch_count = 0;
	int                 other_count = 0;

	// edges counted from the moment the entry is queued, stalled edges left out
	task automatic add_expected(input core_pkg::exe_mem_t e, input int edges);
		expect_q.push_back(e);
		due_q.push_back(moved_edges + edges);
	endtask

	task automatic compare_field(input string name, input logic [31:0] got,
			input logic [31:0] ref_val);
		if (got !== ref_val) begin
			mismatch_count++;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, ref_val);
		end
	endtask

	task automatic check_drained();
		if (expect_q.size() != 0) begin
			other_count++;
			$display("error: %0d expected results never left the stage", expect_q.size());
		end
	endtask

	// first edge after reset release comes before any row is taken
	initial begin
		@(posedge arst_n);
		@(posedge clk);
		if (mem_out.valid !== 1'b0 || mem_out.wr_en !== 1'b0 || mem_out.mem_write !== 1'b0
				|| div_busy !== 1'b0) begin
			mismatch_count++;
			$display("MISMATCH at %0t: outputs not cleared after reset", $time);
		end
	end

	always @(posedge clk) begin
		if (arst_n && !loaded) begin
			// register was frozen at the last edge
			if (mem_out !== last_out) begin
				mismatch_count++;
				$display("MISMATCH at %0t: mem_out changed while stalled", $time);
			end
		end else if (arst_n && mem_out.valid === 1'b1) begin
			if (expect_q.size() == 0) begin
				other_count++;
				$display("error: valid result at %0t with nothing expected", $time);
			end else begin
				want = expect_q.pop_front();
				due  = due_q.pop_front();
				if (moved_edges != due) begin
					other_count++;
					$display("error: result for pc %h came out at %0t, %0d edges off its slot",
						want.pc, $time, moved_edges - due);
				end
				compare_field("pc", 32'(mem_out.pc), 32'(want.pc));
				compare_field("result", mem_out.result, want.result);
				compare_field("store_data", mem_out.store_data, want.store_data);
				compare_field("byte_en", 32'(mem_out.byte_en), 32'(want.byte_en));
				compare_field("mem_write", 32'(mem_out.mem_write), 32'(want.mem_write));
				compare_field("dm_select", 32'(mem_out.dm_select), 32'(want.dm_select));
				compare_field("sel_data", 32'(mem_out.sel_data), 32'(want.sel_data));
				compare_field("rd", 32'(mem_out.rd), 32'(want.rd));
				compare_field("wr_en", 32'(mem_out.wr_en), 32'(want.wr_en));
			end
		end
		loaded   = arst_n && en && !stall;
		last_out = mem_out;
		if (loaded)
			moved_edges++;
	end

endmodule

// File: tb_exe_stage.sv
`timescale 1ns/100ps

module tb_exe_stage;

	typedef struct packed {
		core_pkg::id_exe_t  stim;
		logic               stall;
		logic               flush;
		core_pkg::exe_mem_t exp;
	} row_t;

	localparam int MAX_ROWS = 48;

	// edges from a row being driven until its result is on mem_out, stalls not counted
	localparam int PIPE_EDGES = 2;
	// one edge into EXE, then 34 cycles there for a divide
	localparam int DIV_EDGES  = 35;

	logic               clk;
	logic               arst_n;
	logic               en;
	logic               stall;
	logic               flush;
	core_pkg::id_exe_t  id_in;
	core_pkg::exe_mem_t mem_out;
	logic               div_busy;

	row_t rows [MAX_ROWS];
	int   n_rows = 0;
	int   cycles = 0;
	int   cycle_limit = 0;

	exe_stage u_exe_stage (
		.clk(clk), .arst_n(arst_n), .en(en), .stall(stall), .flush(flush),
		.id_in(id_in), .mem_out(mem_out), .div_busy(div_busy)
	);

	exe_checker u_exe_checker (
		.clk(clk), .arst_n(arst_n), .en(en), .stall(stall),
		.div_busy(div_busy), .mem_out(mem_out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: run still going after %0d cycles", cycles);
			$display("%0d mismatches, %0d other errors",
				u_exe_checker.mismatch_count, u_exe_checker.other_count);
			$display("Simulation failed");
			$finish;
		end
	end

	// pc and rd follow the row number
	function automatic row_t base_row(core_pkg::sel_data_t sel, core_pkg::word_t res);
		row_t r;
		r = '0;
		r.stim.valid    = 1'b1;
		r.stim.pc       = 12'(n_rows * 4);
		r.stim.pc4      = 12'(n_rows * 4 + 4);
		r.stim.rd       = 5'(n_rows % 31 + 1);
		r.stim.wr_en    = 1'b1;
		r.stim.sel_data = sel;
		r.exp.valid     = 1'b1;
		r.exp.pc        = r.stim.pc;
		r.exp.result    = res;
		r.exp.sel_data  = sel;
		r.exp.rd        = r.stim.rd;
		r.exp.wr_en     = 1'b1;
		return r;
	endfunction

	function automatic row_t alu_row(core_pkg::alu_op_t op, core_pkg::word_t a,
			core_pkg::word_t b, logic use_imm, core_pkg::word_t res);
		row_t r;
		r = base_row(core_pkg::SEL_ALU, res);
		r.stim.alu_op      = op;
		r.stim.fwd_opa     = a;
		r.stim.alu_src_imm = use_imm;
		// unused operand slot holds the inverse so a wrong select shows up
		r.stim.fwd_opb = use_imm ? ~b : b;
		r.stim.imm     = use_imm ? b : ~b;
		return r;
	endfunction

	function automatic row_t pc4_row(core_pkg::word_t res);
		row_t r;
		r = alu_row(core_pkg::ALU_ADD, 32'h11, 32'h22, 1'b0, res);
		r.stim.sel_data = core_pkg::SEL_PC4;
		r.exp.sel_data  = core_pkg::SEL_PC4;
		return r;
	endfunction

	function automatic row_t load_row(core_pkg::word_t a, core_pkg::word_t imm,
			core_pkg::word_t addr, core_pkg::dm_sel_t dm);
		row_t r;
		r = alu_row(core_pkg::ALU_ADD, a, imm, 1'b1, addr);
		r.stim.sel_data  = core_pkg::SEL_LOAD;
		r.exp.sel_data   = core_pkg::SEL_LOAD;
		r.stim.dm_select = dm;
		r.exp.dm_select  = dm;
		return r;
	endfunction

	// base register 0x100 plus an immediate for the rest of the address
	function automatic row_t store_row(core_pkg::store_sel_t sel, core_pkg::word_t addr,
			core_pkg::word_t data, core_pkg::byte_en_t be);
		row_t r;
		r = alu_row(core_pkg::ALU_ADD, 32'h100, addr - 32'h100, 1'b1, addr);
		r.stim.is_stype     = 1'b1;
		r.stim.wr_en        = 1'b0;
		r.stim.store_select = sel;
		r.stim.fwd_store    = 32'h89AB_CDEF;
		r.exp.wr_en         = 1'b0;
		r.exp.mem_write     = 1'b1;
		r.exp.store_data    = data;
		r.exp.byte_en       = be;
		return r;
	endfunction

	function automatic row_t div_row(core_pkg::div_op_t op, core_pkg::word_t a,
			core_pkg::word_t b, core_pkg::word_t res);
		row_t r;
		r = base_row(core_pkg::SEL_DIV, res);
		r.stim.div_valid = 1'b1;
		r.stim.div_op    = op;
		r.stim.fwd_opa   = a;
		r.stim.fwd_opb   = b;
		return r;
	endfunction

	function automatic row_t with_stall(row_t r);
		r.stall = 1'b1;
		return r;
	endfunction

	// thrown away by the flush row behind it
	function automatic row_t discarded(row_t r);
		r.exp = '0;
		return r;
	endfunction

	function automatic row_t flush_row();
		row_t r;
		r = '0;
		r.flush = 1'b1;
		return r;
	endfunction

	task automatic add_row(input row_t r);
		rows[n_rows] = r;
		n_rows++;
	endtask

	task automatic build_table();
		add_row(alu_row(core_pkg::ALU_ADD, 32'd5, 32'd7, 1'b0, 32'd12));
		add_row(alu_row(core_pkg::ALU_ADD, 32'h1000, 32'hFFFF_FFFF, 1'b1, 32'h0FFF));
		add_row(alu_row(core_pkg::ALU_SUB, 32'd3, 32'd5, 1'b0, 32'hFFFF_FFFE));
		add_row(alu_row(core_pkg::ALU_SLL, 32'd1, 32'd31, 1'b1, 32'h8000_0000));
		add_row(alu_row(core_pkg::ALU_SLL, 32'hF0, 32'h24, 1'b0, 32'hF00));
		add_row(alu_row(core_pkg::ALU_SRL, 32'h8000_0000, 32'd4, 1'b0, 32'h0800_0000));
		add_row(alu_row(core_pkg::ALU_SRA, 32'h8000_0000, 32'd4, 1'b1, 32'hF800_0000));
		add_row(alu_row(core_pkg::ALU_SLT, 32'hFFFF_FFFF, 32'd1, 1'b0, 32'd1));
		add_row(alu_row(core_pkg::ALU_SLTU, 32'hFFFF_FFFF, 32'd1, 1'b0, 32'd0));
		add_row(alu_row(core_pkg::ALU_SLT, 32'd5, 32'hFFFF_FFFE, 1'b1, 32'd0));
		add_row(alu_row(core_pkg::ALU_SLTU, 32'd1, 32'hFFFF_FFFF, 1'b1, 32'd1));
		add_row(alu_row(core_pkg::ALU_XOR, 32'hF0F0_F0F0, 32'hFF00_FF00, 1'b0, 32'h0FF0_0FF0));
		add_row(alu_row(core_pkg::ALU_OR, 32'hF0F0_0000, 32'h0F0F, 1'b1, 32'hF0F0_0F0F));
		add_row(alu_row(core_pkg::ALU_AND, 32'hF0F0_F0F0, 32'h0FF0_0FF0, 1'b0, 32'h00F0_00F0));
		add_row(alu_row(core_pkg::ALU_PASS_B, 32'h1234, 32'hABCD_E000, 1'b1, 32'hABCD_E000));
		// row 15 sits at pc 0x3c so pc4 is 0x40
		add_row(pc4_row(32'h0000_0040));
		add_row(load_row(32'h2000, 32'hFFFF_FFFC, 32'h1FFC, 3'd2));
		add_row(store_row(core_pkg::ST_BYTE, 32'h100, 32'hEFEF_EFEF, 4'b0001));
		add_row(store_row(core_pkg::ST_BYTE, 32'h101, 32'hEFEF_EFEF, 4'b0010));
		add_row(store_row(core_pkg::ST_BYTE, 32'h102, 32'hEFEF_EFEF, 4'b0100));
		add_row(store_row(core_pkg::ST_BYTE, 32'h103, 32'hEFEF_EFEF, 4'b1000));
		add_row(store_row(core_pkg::ST_HALF, 32'h104, 32'hCDEF_CDEF, 4'b0011));
		add_row(store_row(core_pkg::ST_HALF, 32'h106, 32'hCDEF_CDEF, 4'b1100));
		add_row(store_row(core_pkg::ST_WORD, 32'h108, 32'h89AB_CDEF, 4'b1111));
		add_row(with_stall(alu_row(core_pkg::ALU_SUB, 32'd100, 32'd1, 1'b1, 32'd99)));
		add_row(div_row(core_pkg::DIV_DIV, 32'hFFFF_FFF9, 32'd2, 32'hFFFF_FFFD));
		add_row(alu_row(core_pkg::ALU_ADD, 32'd40, 32'd2, 1'b0, 32'd42));
		add_row(div_row(core_pkg::DIV_DIVU, 32'hFFFF_FFF9, 32'd2, 32'h7FFF_FFFC));
		add_row(div_row(core_pkg::DIV_REM, 32'hFFFF_FFF9, 32'd2, 32'hFFFF_FFFF));
		add_row(div_row(core_pkg::DIV_REMU, 32'hFFFF_FFF9, 32'd2, 32'd1));
		add_row(div_row(core_pkg::DIV_DIV, 32'd20, 32'hFFFF_FFFD, 32'hFFFF_FFFA));
		add_row(div_row(core_pkg::DIV_REM, 32'd20, 32'hFFFF_FFFD, 32'd2));
		add_row(div_row(core_pkg::DIV_DIV, 32'h1234, 32'd0, 32'hFFFF_FFFF));
		add_row(div_row(core_pkg::DIV_REMU, 32'h1234, 32'd0, 32'h1234));
		add_row(div_row(core_pkg::DIV_DIV, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000));
		add_row(div_row(core_pkg::DIV_REM, 32'h8000_0000, 32'hFFFF_FFFF, 32'd0));
		add_row(with_stall(alu_row(core_pkg::ALU_XOR, 32'hFF, 32'h0F, 1'b0, 32'hF0)));
		add_row(discarded(alu_row(core_pkg::ALU_OR, 32'h5, 32'h3, 1'b0, 32'h7)));
		add_row(flush_row());
		add_row(discarded(div_row(core_pkg::DIV_DIV, 32'd100, 32'd7, 32'd14)));
		add_row(flush_row());
		add_row(alu_row(core_pkg::ALU_AND, 32'hFFFF, 32'h00FF_FF00, 1'b1, 32'hFF00));
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	initial begin
		arst_n = 1'b0;
		en     = 1'b1;
		stall  = 1'b0;
		flush  = 1'b0;
		id_in  = '0;
		build_table();
		cycle_limit = n_rows * 40 + 100;
		repeat (8) @(posedge clk);
		#1 arst_n = 1'b1;
		for (int i = 0; i < n_rows; i++) begin
			next_cycle();
			// a flush row lands part way into a running divide
			if (rows[i].flush && div_busy)
				repeat (10) next_cycle();
			else
				while (div_busy) next_cycle();
			id_in = rows[i].stim;
			stall = rows[i].stall;
			flush = rows[i].flush;
			if (rows[i].exp.valid)
				u_exe_checker.add_expected(rows[i].exp,
					rows[i].stim.div_valid ? DIV_EDGES : PIPE_EDGES);
			// stalled row is taken at the edge after the stall
			if (rows[i].stall) begin
				next_cycle();
				stall = 1'b0;
			end
		end
		next_cycle();
		while (div_busy) next_cycle();
		id_in = '0;
		flush = 1'b0;
		repeat (6) next_cycle();
		u_exe_checker.check_drained();
		$display("%0d mismatches, %0d other errors",
			u_exe_checker.mismatch_count, u_exe_checker.other_count);
		if (u_exe_checker.mismatch_count == 0 && u_exe_checker.other_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: files.f
core_pkg.sv
id_exe_reg.sv
alu.sv
divider.sv
store_align.sv
exe_mem_reg.sv
exe_stage.sv
exe_checker.sv
tb_exe_stage.sv

// File: Bender.yml
package:
  name: exe_stage

sources:
  - core_pkg.sv
  - id_exe_reg.sv
  - alu.sv
  - divider.sv
  - store_align.sv
  - exe_mem_reg.sv
  - exe_stage.sv
  - target: simulation
    files:
      - exe_checker.sv
      - tb_exe_stage.sv
